// ==== Makefile ====
TOP := tb_mpf_tx_shim

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f sources.f --top-module $(TOP) -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== bench/mpf_tx_shim_properties.sv ====
// Concurrent assertions on host stall, dequeue and reset behavior, plus their bind to the top level
module mpf_tx_shim_properties
    import mpf_pkg::*;
(
    input logic         clk,
    input logic         arst_n,
    input mpf_tx_pair_t afu_tx,
    input mpf_tx_pair_t host_tx,
    input logic         host_alm_full,
    input logic         deq
);

    timeunit 1ns;
    timeprecision 100ps;

    logic                 host_any;
    logic                 afu_any;
    logic [MPF_CNT_W-1:0] occupancy;

    assign host_any = host_tx.c0.rd_valid || host_tx.c1.wr_valid || host_tx.c1.irq_valid;
    // Any valid bit from the accelerator takes one buffer slot
    assign afu_any  = afu_tx.c0.rd_valid || afu_tx.c1.wr_valid || afu_tx.c1.irq_valid;

    // Own count of buffered entries, one in per request and one out per pop
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + MPF_CNT_W'(afu_any) - MPF_CNT_W'(deq);
        end
    end

    // ==============================
    // Properties
    // ==============================

    // A high host level stops issue from the next cycle on
    no_issue_after_alm_full: assert property (@(posedge clk) disable iff (!arst_n)
        host_alm_full |=> !host_any)
        else $error("host valid in the cycle after host almost-full");

    // The pop pulse only fires while an entry is buffered
    no_deq_when_empty: assert property (@(posedge clk) disable iff (!arst_n)
        deq |-> (occupancy != '0))
        else $error("dequeue while the buffer is empty");

    // Host strobes stay quiet while reset is held
    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !host_any)
        else $error("host valid during reset");

endmodule

bind mpf_tx_shim_top mpf_tx_shim_properties u_props (
    .clk           (clk),
    .arst_n        (arst_n),
    .afu_tx        (afu_tx),
    .host_tx       (host_tx),
    .host_alm_full (host_alm_full),
    .deq           (deq)
);

// ==== bench/tb_mpf_tx_shim.sv ====
// Request shim testbench with clock, reset, xorshift stimulus, reference queue and compare tasks
module tb_mpf_tx_shim
    import mpf_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // Length of the random phase and bounds for the drain and the idle tail
    localparam int RUN_CYCLES  = 600;
    localparam int DRAIN_LIMIT = 200;
    localparam int IDLE_TAIL   = 8;
    // Clear host cycles needed before issue resumes
    // They cover the stall cycle, the counted quiet cycles and the done cycle
    localparam int RESUME_GAP  = MPF_QUIET_CYCLES + 2;

    logic         clk;
    logic         arst_n;
    mpf_tx_pair_t afu_tx;
    logic         afu_alm_full;
    mpf_tx_pair_t host_tx;
    logic         host_alm_full;

    // Sent entries that the host has not seen yet with the oldest first
    mpf_tx_pair_t exp_q[$];
    logic [31:0]  rng_state;
    int           host_hold;
    int           late_cnt;
    // afu_alm_full as seen in the middle of the last cycle
    logic         alm_seen     = 1'b0;
    // Consecutive cycles with host_alm_full low, starting from a clear host
    int           clear_streak = RESUME_GAP;

    mpf_tx_shim_top UUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .afu_tx        (afu_tx),
        .afu_alm_full  (afu_alm_full),
        .host_tx       (host_tx),
        .host_alm_full (host_alm_full)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // ==============================
    // Helpers and reference
    // ==============================

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic any_valid(input mpf_tx_pair_t p);
        return p.c0.rd_valid || p.c1.wr_valid || p.c1.irq_valid;
    endfunction

    // Expected host word with only the fields that the valid bits make meaningful filled in
    function automatic mpf_tx_pair_t expected_host(input mpf_tx_pair_t sent);
        mpf_tx_pair_t want;
        want = '0;
        want.c0.rd_valid  = sent.c0.rd_valid;
        want.c1.wr_valid  = sent.c1.wr_valid;
        want.c1.irq_valid = sent.c1.irq_valid;
        if (sent.c0.rd_valid) begin
            want.c0.addr = sent.c0.addr;
            want.c0.tag  = sent.c0.tag;
        end
        // An interrupt uses the vector view and anything else on channel 1 is a write
        if (sent.c1.irq_valid) begin
            want.c1.hdr.irq.vector = sent.c1.hdr.irq.vector;
        end else if (sent.c1.wr_valid) begin
            want.c1.hdr.mem.addr = sent.c1.hdr.mem.addr;
            want.c1.hdr.mem.tag  = sent.c1.hdr.mem.tag;
            want.c1.data         = sent.c1.data;
        end
        return want;
    endfunction

    // ==============================
    // Compare tasks
    // ==============================

    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [MPF_DATA_W-1:0] want,
                               input logic [MPF_DATA_W-1:0] got);
        if (want !== got) begin
            $display("[FAIL] time %0t %s expected 0x%0h actual 0x%0h", $time, name, want, got);
            stop_run();
        end
    endtask

    task automatic compare_level(input string name, input logic want, input logic got);
        if (want !== got) begin
            $display("[FAIL] time %0t %s expected %b actual %b", $time, name, want, got);
            stop_run();
        end
    endtask

    task automatic compare_c0(input mpf_c0_tx_t want, input mpf_c0_tx_t got);
        compare_level("host_tx.c0.rd_valid", want.rd_valid, got.rd_valid);
        if (want.rd_valid) begin
            check_field("host_tx.c0.addr", MPF_DATA_W'(want.addr), MPF_DATA_W'(got.addr));
            check_field("host_tx.c0.tag", MPF_DATA_W'(want.tag), MPF_DATA_W'(got.tag));
        end
    endtask

    task automatic compare_c1(input mpf_c1_tx_t want, input mpf_c1_tx_t got);
        compare_level("host_tx.c1.wr_valid", want.wr_valid, got.wr_valid);
        compare_level("host_tx.c1.irq_valid", want.irq_valid, got.irq_valid);
        if (want.irq_valid) begin
            check_field("host_tx.c1.hdr.irq.vector", MPF_DATA_W'(want.hdr.irq.vector),
                        MPF_DATA_W'(got.hdr.irq.vector));
        end else if (want.wr_valid) begin
            check_field("host_tx.c1.hdr.mem.addr", MPF_DATA_W'(want.hdr.mem.addr),
                        MPF_DATA_W'(got.hdr.mem.addr));
            check_field("host_tx.c1.hdr.mem.tag", MPF_DATA_W'(want.hdr.mem.tag),
                        MPF_DATA_W'(got.hdr.mem.tag));
            check_field("host_tx.c1.data", want.data, got.data);
        end
    endtask

    // ==============================
    // Stimulus
    // ==============================

    // One rising edge worth of host back-pressure and accelerator requests
    task automatic drive_cycle();
        mpf_tx_pair_t entry;
        logic [31:0]  r;
        logic         may_send;
        entry = '0;
        // Random host pulses that may start again inside the quiet wait of the previous one
        if (host_hold > 0) begin
            host_alm_full <= 1'b1;
            host_hold--;
        end else begin
            host_alm_full <= 1'b0;
            if (next_rand() % 12 == 0) begin
                host_hold = 1 + int'(next_rand() % 6);
            end
        end
        // One entry may already be in flight when the level is first seen
        if (!alm_seen) begin
            late_cnt = 0;
        end
        may_send = !alm_seen || (late_cnt < MPF_THRESHOLD - 1);
        r = next_rand();
        if (may_send && r[1:0] != 2'b00) begin
            entry.c0.addr      = MPF_ADDR_W'(next_rand());
            entry.c0.tag       = MPF_TAG_W'(next_rand());
            entry.c1.hdr       = MPF_C1_HDR_W'({next_rand(), next_rand()});
            entry.c1.data      = {next_rand(), next_rand()};
            entry.c0.rd_valid  = r[2];
            entry.c1.wr_valid  = (r[4:3] == 2'd1);
            entry.c1.irq_valid = (r[4:3] == 2'd2);
            if (!any_valid(entry)) begin
                entry.c0.rd_valid = 1'b1;
            end
            exp_q.push_back(entry);
            afu_tx <= entry;
            if (alm_seen) begin
                late_cnt++;
            end
        end else begin
            afu_tx <= '0;
        end
    endtask

    initial begin
        int wait_cnt;
        rng_state = 32'd57;
        host_hold = 0;
        late_cnt  = 0;
        arst_n        <= 1'b0;
        afu_tx        <= '0;
        host_alm_full <= 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < RUN_CYCLES; i++) begin
            @(posedge clk);
            drive_cycle();
        end
        // Drain with the host clear until every sent entry has been seen
        wait_cnt = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            afu_tx        <= '0;
            host_alm_full <= 1'b0;
            wait_cnt++;
            if (wait_cnt > DRAIN_LIMIT) begin
                $display("Timeout: %0d entries never reached the host", exp_q.size());
                $display("Done: errors found");
                $fatal(1);
            end
        end
        // A few idle cycles so a stray host valid would still be caught
        for (int i = 0; i < IDLE_TAIL; i++) begin
            @(posedge clk);
        end
        $display("Done: no errors");
        $finish;
    end

    // ==============================
    // Compare process
    // ==============================

    // Outputs are sampled at the falling edge half a cycle after the inputs moved
    always @(negedge clk) begin : check_cycle
        int           occupancy;
        logic         may_issue;
        logic         host_valid;
        mpf_tx_pair_t want;
        if (arst_n) begin
            // The entry on afu_tx right now only lands in the FIFO at the next edge
            occupancy = exp_q.size() - (any_valid(afu_tx) ? 1 : 0);
            alm_seen  = afu_alm_full;
            compare_level("afu_alm_full", (MPF_N_ENTRIES - occupancy) <= MPF_THRESHOLD,
                          afu_alm_full);
            // Issue happens exactly when the host has been clear long enough and an entry waits
            host_valid = any_valid(host_tx);
            may_issue  = (clear_streak >= RESUME_GAP) && (occupancy > 0);
            compare_level("host_tx valid", may_issue, host_valid);
            if (host_valid) begin
                want = expected_host(exp_q.pop_front());
                compare_c0(want.c0, host_tx.c0);
                compare_c1(want.c1, host_tx.c1);
            end
            if (host_alm_full) begin
                clear_streak = 0;
            end else if (clear_streak < RESUME_GAP) begin
                clear_streak++;
            end
        end
    end

endmodule

// ==== design/mpf_fifo_lutram.sv ====
// Circular storage FIFO with occupancy count, almost-full level and first-word-visible head
module mpf_fifo_lutram
    import mpf_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  mpf_tx_pair_t enq_data,
    input  logic         enq_en,
    input  logic         deq_en,
    output mpf_tx_pair_t first,
    output logic         not_empty,
    output logic         almost_full
);

    // Storage array, written on enqueue and read asynchronously at the head
    mpf_tx_pair_t         mem [MPF_N_ENTRIES];
    logic [MPF_PTR_W-1:0] wr_ptr;
    logic [MPF_PTR_W-1:0] rd_ptr;
    logic [MPF_CNT_W-1:0] count;
    logic [MPF_CNT_W-1:0] free_slots;
    logic                 not_full;
    logic                 do_enq;
    logic                 do_deq;

    // Pointer advance with explicit wrap so the depth need not be a power of two
    function automatic logic [MPF_PTR_W-1:0] ptr_inc(input logic [MPF_PTR_W-1:0] p);
        if (p == MPF_PTR_W'(MPF_N_ENTRIES - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // ==============================
    // Qualified strobes
    // ==============================

    // A dequeue of an empty FIFO is ignored
    assign do_deq = deq_en && not_empty;
    // When full an enqueue is only taken if the head leaves in the same cycle
    assign do_enq = enq_en && (not_full || do_deq);

    // ==============================
    // Storage
    // ==============================

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // Head word is visible without a read cycle
    assign first = mem[rd_ptr];

    // ==============================
    // Pointers and occupancy
    // ==============================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_deq) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Enqueue and dequeue together leave the count unchanged
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign not_empty = (count != '0);
    assign not_full  = (count != MPF_CNT_W'(MPF_N_ENTRIES));

    // Almost-full comes from the registered count, so it is stable all cycle
    assign free_slots  = MPF_CNT_W'(MPF_N_ENTRIES) - count;
    assign almost_full = (free_slots <= MPF_CNT_W'(MPF_THRESHOLD));

endmodule

// ==== design/mpf_pkg.sv ====
// Request widths, buffer depth and threshold, quiet period, pacer state codes, request types
package mpf_pkg;

    // ==============================
    // Field widths
    // ==============================

    // Request address, shared by the channel 0 read and the channel 1 write header
    localparam int MPF_ADDR_W = 32;
    // Request tag, carried but never interpreted by the shim
    localparam int MPF_TAG_W = 8;
    // Write payload carried on channel 1
    localparam int MPF_DATA_W = 64;
    // Interrupt vector id in the interrupt view of the channel 1 header
    localparam int MPF_IRQ_W = 4;

    // The channel 1 header word is sized by its memory view
    localparam int MPF_C1_HDR_W = MPF_ADDR_W + MPF_TAG_W;
    // Unused upper bits of the interrupt view
    localparam int MPF_IRQ_PAD_W = MPF_C1_HDR_W - MPF_IRQ_W;

    // ==============================
    // Buffer and pacing
    // ==============================

    // Lockstep FIFO depth in pair entries
    localparam int MPF_N_ENTRIES = 8;
    // Almost-full rises when free slots are at or below this value
    localparam int MPF_THRESHOLD = 4;
    // Consecutive clear host cycles required before the pacer resumes
    localparam int MPF_QUIET_CYCLES = 3;

    // Pointer and occupancy widths, the count has to hold the full depth
    localparam int MPF_PTR_W = $clog2(MPF_N_ENTRIES);
    localparam int MPF_CNT_W = $clog2(MPF_N_ENTRIES + 1);
    // Quiet timer saturates at MPF_QUIET_CYCLES
    localparam int MPF_QT_W = $clog2(MPF_QUIET_CYCLES + 1);

    // Pacer state encodings
    localparam int MPF_ST_W = 2;
    localparam logic [MPF_ST_W-1:0] MPF_ST_RUN = 2'd0;
    localparam logic [MPF_ST_W-1:0] MPF_ST_STALL = 2'd1;
    localparam logic [MPF_ST_W-1:0] MPF_ST_QUIET = 2'd2;

    // ==============================
    // Request types
    // ==============================

    // Channel 0 read request
    typedef struct packed {
        logic                  rd_valid;
        logic [MPF_ADDR_W-1:0] addr;
        logic [MPF_TAG_W-1:0]  tag;
    } mpf_c0_tx_t;

    // Memory-write view of the channel 1 header
    typedef struct packed {
        logic [MPF_ADDR_W-1:0] addr;
        logic [MPF_TAG_W-1:0]  tag;
    } mpf_c1_mem_hdr_t;

    // Interrupt view of the channel 1 header, vector id in the low bits
    typedef struct packed {
        logic [MPF_IRQ_PAD_W-1:0] pad;
        logic [MPF_IRQ_W-1:0]     vector;
    } mpf_c1_irq_hdr_t;

    // One header word, decoded by irq_valid versus wr_valid
    typedef union packed {
        mpf_c1_mem_hdr_t mem;
        mpf_c1_irq_hdr_t irq;
    } mpf_c1_hdr_u;

    // Channel 1 write or interrupt request
    typedef struct packed {
        logic                  wr_valid;
        logic                  irq_valid;
        mpf_c1_hdr_u           hdr;
        logic [MPF_DATA_W-1:0] data;
    } mpf_c1_tx_t;

    // Lockstep pair, this is the FIFO word
    typedef struct packed {
        mpf_c0_tx_t c0;
        mpf_c1_tx_t c1;
    } mpf_tx_pair_t;

endpackage

// ==== design/mpf_quiet_timer.sv ====
// Saturating counter of consecutive clear host cycles with a quiet-done flag
module mpf_quiet_timer
    import mpf_pkg::*;
(
    input  logic clk,
    input  logic arst_n,
    // Count enable, any low cycle restarts the measurement
    input  logic run,
    // High once MPF_QUIET_CYCLES consecutive run cycles have been seen
    output logic quiet_done
);

    logic [MPF_QT_W-1:0] count;

    // ==============================
    // Counter
    // ==============================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (count != MPF_QT_W'(MPF_QUIET_CYCLES)) begin
            count <= count + 1'b1;
        end
    end

    // Registered compare, so done appears the cycle after the last counted one
    // and holds while run stays high
    assign quiet_done = (count == MPF_QT_W'(MPF_QUIET_CYCLES));

endmodule

// ==== design/mpf_shim_buffer_lockstep.sv ====
// Lockstep request buffer holding channel 0 and channel 1 together in one FIFO entry
module mpf_shim_buffer_lockstep
    import mpf_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    // Raw requests from the accelerator, valid bits are per-cycle strobes
    input  mpf_tx_pair_t afu_tx,
    // Level back to the accelerator, a few more entries may still arrive
    output logic         afu_alm_full,
    // Buffered head, valids already qualified by non-empty
    output mpf_tx_pair_t head_tx,
    // One pulse moves both channels of the head out together
    input  logic         deq
);

    // ==============================
    // Enqueue side
    // ==============================

    logic         c0_enq;
    logic         c1_enq;
    logic         enq_en;
    logic         not_empty;
    logic         almost_full;
    mpf_tx_pair_t first;

    // A read alone, a write or interrupt alone, or both at once all take one slot
    assign c0_enq = afu_tx.c0.rd_valid;
    assign c1_enq = afu_tx.c1.wr_valid || afu_tx.c1.irq_valid;
    assign enq_en = c0_enq || c1_enq;

    // Both channels share one almost-full level
    assign afu_alm_full = almost_full;

    mpf_fifo_lutram u_fifo (
        .clk         (clk),
        .arst_n      (arst_n),
        .enq_data    (afu_tx),
        .enq_en      (enq_en),
        .deq_en      (deq),
        .first       (first),
        .not_empty   (not_empty),
        .almost_full (almost_full)
    );

    // ==============================
    // Head presentation
    // ==============================

    // The storage word is undefined when the FIFO is empty (stale or never
    // written), so each valid bit is forced low until a real entry is present
    always_comb begin
        head_tx = first;
        head_tx.c0.rd_valid  = first.c0.rd_valid && not_empty;
        head_tx.c1.wr_valid  = first.c1.wr_valid && not_empty;
        head_tx.c1.irq_valid = first.c1.irq_valid && not_empty;
    end

endmodule

// ==== design/mpf_tx_pacer_fsm.sv ====
// Pacing FSM that drains the lockstep head toward the host and stalls on host almost-full
module mpf_tx_pacer_fsm
    import mpf_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    // Gated head of the lockstep buffer
    input  mpf_tx_pair_t head_tx,
    // Host back-pressure level
    input  logic         host_alm_full,
    // Quiet period complete, from the timer
    input  logic         quiet_done,
    // Timer counts while this is high and clears while it is low
    output logic         timer_run,
    // Pulse that pops the buffer head
    output logic         deq,
    // Request toward the host, valids are strobes for this cycle
    output mpf_tx_pair_t host_tx
);

    logic [MPF_ST_W-1:0] state;
    logic [MPF_ST_W-1:0] state_nxt;
    logic                head_valid;

    // ==============================
    // State register
    // ==============================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= MPF_ST_RUN;
        end else begin
            state <= state_nxt;
        end
    end

    // Run issues freely, stall waits for the host to clear, and quiet waits
    // for the timer. A new almost-full during quiet falls back to stall
    always_comb begin
        state_nxt = state;
        case (state)
            MPF_ST_RUN: begin
                if (host_alm_full) begin
                    state_nxt = MPF_ST_STALL;
                end
            end
            MPF_ST_STALL: begin
                if (!host_alm_full) begin
                    state_nxt = MPF_ST_QUIET;
                end
            end
            MPF_ST_QUIET: begin
                if (host_alm_full) begin
                    state_nxt = MPF_ST_STALL;
                end else if (quiet_done) begin
                    state_nxt = MPF_ST_RUN;
                end
            end
            default: state_nxt = MPF_ST_RUN;
        endcase
    end

    // ==============================
    // Issue path
    // ==============================

    assign head_valid = head_tx.c0.rd_valid || head_tx.c1.wr_valid || head_tx.c1.irq_valid;

    // Same-cycle dequeue, the cycle that sees almost-full may still issue
    assign deq = (state == MPF_ST_RUN) && head_valid;

    // Forward the head, both channels qualified by the one dequeue decision
    always_comb begin
        host_tx = head_tx;
        host_tx.c0.rd_valid  = head_tx.c0.rd_valid && deq;
        host_tx.c1.wr_valid  = head_tx.c1.wr_valid && deq;
        host_tx.c1.irq_valid = head_tx.c1.irq_valid && deq;
    end

    // Only clear cycles spent in quiet count toward the resume
    assign timer_run = (state == MPF_ST_QUIET) && !host_alm_full;

endmodule

// ==== design/mpf_tx_shim_top.sv ====
// Request-side shim top level joining the lockstep buffer, pacing FSM and quiet timer
module mpf_tx_shim_top
    import mpf_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    // Accelerator side
    input  mpf_tx_pair_t afu_tx,
    output logic         afu_alm_full,
    // Host side
    output mpf_tx_pair_t host_tx,
    input  logic         host_alm_full
);

    // ==============================
    // Internal connections
    // ==============================

    // Buffer head with valids gated by non-empty
    mpf_tx_pair_t head_tx;
    // Pop pulse from the pacer
    logic         deq;
    // Quiet measurement handshake between pacer and timer
    logic         timer_run;
    logic         quiet_done;

    mpf_shim_buffer_lockstep u_buffer (
        .clk          (clk),
        .arst_n       (arst_n),
        .afu_tx       (afu_tx),
        .afu_alm_full (afu_alm_full),
        .head_tx      (head_tx),
        .deq          (deq)
    );

    mpf_tx_pacer_fsm u_pacer (
        .clk           (clk),
        .arst_n        (arst_n),
        .head_tx       (head_tx),
        .host_alm_full (host_alm_full),
        .quiet_done    (quiet_done),
        .timer_run     (timer_run),
        .deq           (deq),
        .host_tx       (host_tx)
    );

    mpf_quiet_timer u_timer (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (timer_run),
        .quiet_done (quiet_done)
    );

endmodule

// ==== sources.f ====
design/mpf_pkg.sv
design/mpf_fifo_lutram.sv
design/mpf_shim_buffer_lockstep.sv
design/mpf_tx_pacer_fsm.sv
design/mpf_quiet_timer.sv
design/mpf_tx_shim_top.sv
bench/mpf_tx_shim_properties.sv
bench/tb_mpf_tx_shim.sv
